/* common/board_params.svh */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// ========================================
// board widths
// ========================================
`define KEY_WIDTH       2      // push buttons
`define SW_WIDTH        4      // slide switches
`define LED_WIDTH       8      // user leds
`define MEM_ADDR_WIDTH  4      // 16 boot entries
`define INSTR_WIDTH     12     // addr[11:8] over data[7:0]

// ========================================
// host bus and register map
// ========================================
`define APB_ADDR_WIDTH  4
`define APB_DATA_WIDTH  32
`define REG_CTRL_OFF    4'h0   // mode and reset requests
`define REG_INSTR_OFF   4'h4   // boot memory write word
`define REG_STATUS_OFF  4'h8   // keys and switches, read only

// control register bits
`define CTRL_MODE_BIT   0
`define CTRL_COLD_BIT   1
`define CTRL_WARM_BIT   2
`define CTRL_DEBUG_BIT  3

// status word field positions
`define STATUS_KEY_LSB  0
`define STATUS_SW_LSB   4

// timing
`define DEBOUNCE_CYCLES 50000  // 1 ms at 50 MHz
`define COLD_PULSE      6
`define WARM_PULSE      2
`define DEBUG_PULSE     32

`endif

/* common/board_pkg.sv */
`default_nettype none

`include "board_params.svh"

package board_pkg;

  // fabric side signal types
  typedef logic [`KEY_WIDTH-1:0]      key_t;       // buttons
  typedef logic [`SW_WIDTH-1:0]       sw_t;        // slide switches
  typedef logic [`LED_WIDTH-1:0]      led_t;       // led byte
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;  // boot memory index
  typedef logic [7:0]                 mem_data_t;  // one boot entry

  // fabric operating mode
  // load lets the host fill the boot memory
  // run lets the switches read it onto the leds
  typedef enum logic [0:0] {
    MODE_LOAD = 1'b0,
    MODE_RUN  = 1'b1
  } mode_t;

endpackage : board_pkg

`default_nettype wire

/* common/host_pkg.sv */
`default_nettype none

`include "board_params.svh"

package host_pkg;

  // apb side types
  typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;  // byte offset
  typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;  // one bus word

  // decoded register select
  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,  // mode + reset requests
    REG_INSTR  = 2'd1,  // boot memory instruction
    REG_STATUS = 2'd2,  // keys + switches
    REG_NONE   = 2'd3   // unmapped offset
  } reg_sel_t;

endpackage : host_pkg

`default_nettype wire

/* verilog/key_debounce.sv */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module key_debounce #(
  parameter int timeout = `DEBOUNCE_CYCLES  // stable cycles, 2 or more
) (
  input  logic            fpga_clk_50,
  input  logic            reset,
  input  board_pkg::key_t key,           // raw buttons, low = pressed
  output board_pkg::key_t keys_pressed   // filtered, high = pressed
);
  import board_pkg::*;

  localparam int cnt_w = $clog2(timeout);

  key_t key_meta;
  key_t key_sync;
  key_t key_level;   // pressed polarity

  // ========================================
  // input synchronizer
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (reset) begin
      key_meta <= '1;        // idle buttons read high
      key_sync <= '1;
    end else begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  assign key_level = ~key_sync;

  // ========================================
  // per key stability counter
  // ========================================
  for (genvar i = 0; i < `KEY_WIDTH; i++) begin : g_key
    logic [cnt_w-1:0] cnt;        // cycles spent away from output
    logic             pressed_q;

    always_ff @(posedge fpga_clk_50) begin
      if (reset) begin
        cnt       <= '0;
        pressed_q <= 1'b0;
      end else if (key_level[i] == pressed_q) begin
        cnt       <= '0;          // agrees again, restart
      end else if (cnt == cnt_w'(timeout - 1)) begin
        cnt       <= '0;
        pressed_q <= key_level[i]; // held long enough, take it
      end else begin
        cnt       <= cnt + 1'b1;
      end
    end

    assign keys_pressed[i] = pressed_q;
  end

endmodule : key_debounce

`default_nettype wire

/* reset_pulse/reset_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

// rising edge on req -> low pulse of pulse_ext cycles
module reset_pulse #(
  parameter int pulse_ext = 6  // low time in clocks, 1 or more
) (
  input  logic fpga_clk_50,
  input  logic reset,
  input  logic req,      // level request from host reg
  output logic pulse_n   // low active stretched pulse
);

  localparam int cnt_w = $clog2(pulse_ext + 1);

  logic             req_q;   // previous req level
  logic             rise;
  logic             busy;
  logic [cnt_w-1:0] cnt;     // remaining low cycles

  // ========================================
  // edge detect
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (reset) req_q <= 1'b0;
    else       req_q <= req;
  end

  assign rise = req & ~req_q;  // falling edge gives nothing
  assign busy = (cnt != '0);

  // ========================================
  // stretch counter
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (reset) begin
      cnt <= '0;
    end else if (busy) begin
      cnt <= cnt - 1'b1;               // new edges ignored while busy
    end else if (rise) begin
      cnt <= cnt_w'(pulse_ext);        // start pulse next cycle
    end
  end

  // low for exactly pulse_ext cycles
  assign pulse_n = ~busy;

endmodule : reset_pulse

`default_nettype wire

/* host_regs/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module host_regs (
  input  logic                 fpga_clk_50,
  input  logic                 reset,
  // apb slave, no wait states
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  host_pkg::apb_addr_t  paddr,
  input  host_pkg::apb_data_t  pwdata,
  output host_pkg::apb_data_t  prdata,
  output logic                 pready,
  output logic                 pslverr,
  // status sources
  input  board_pkg::key_t      keys_pressed,
  input  board_pkg::sw_t       sw_sync,
  // fabric controls
  output board_pkg::mode_t     mode,
  output logic                 mem_we,
  output board_pkg::mem_addr_t mem_waddr,
  output board_pkg::mem_data_t mem_wdata,
  output logic                 cold_req,
  output logic                 warm_req,
  output logic                 debug_req
);
  import board_pkg::*;
  import host_pkg::*;

  reg_sel_t                sel;
  logic                    access;       // apb access phase
  logic                    wr_en;
  logic [3:0]              ctrl_q;       // debug, warm, cold, mode
  logic [`INSTR_WIDTH-1:0] instr_q;
  apb_data_t               status_word;

  // ========================================
  // address decode
  // ========================================
  always_comb begin
    case (paddr)
      `REG_CTRL_OFF:   sel = REG_CTRL;
      `REG_INSTR_OFF:  sel = REG_INSTR;
      `REG_STATUS_OFF: sel = REG_STATUS;
      default:         sel = REG_NONE;  // slverr
    endcase
  end

  assign access  = psel & penable;
  assign wr_en   = access & pwrite & (sel != REG_NONE);
  assign pready  = access;                       // always ready
  assign pslverr = access & (sel == REG_NONE);

  // ========================================
  // writable registers
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (reset) begin
      ctrl_q  <= '0;   // load mode, no requests
      instr_q <= '0;
    end else if (wr_en) begin
      if (sel == REG_CTRL)  ctrl_q  <= pwdata[3:0];
      if (sel == REG_INSTR) instr_q <= pwdata[`INSTR_WIDTH-1:0];
      // status is read only, writes drop
    end
  end

  assign mode      = mode_t'(ctrl_q[`CTRL_MODE_BIT]);
  assign cold_req  = ctrl_q[`CTRL_COLD_BIT];
  assign warm_req  = ctrl_q[`CTRL_WARM_BIT];
  assign debug_req = ctrl_q[`CTRL_DEBUG_BIT];

  // memory write straight off the bus in the access cycle
  // only honoured in load mode
  assign mem_we    = wr_en & (sel == REG_INSTR) & (mode == MODE_LOAD);
  assign mem_waddr = pwdata[$bits(mem_data_t) +: `MEM_ADDR_WIDTH];  // bits 11:8
  assign mem_wdata = pwdata[0 +: $bits(mem_data_t)];                // bits 7:0

  // ========================================
  // readback
  // ========================================
  always_comb begin
    status_word = '0;
    status_word[`STATUS_KEY_LSB +: `KEY_WIDTH] = keys_pressed;
    status_word[`STATUS_SW_LSB +: `SW_WIDTH]   = sw_sync;
  end

  always_comb begin
    case (sel)
      REG_CTRL:   prdata = apb_data_t'(ctrl_q);
      REG_INSTR:  prdata = apb_data_t'(instr_q);
      REG_STATUS: prdata = status_word;
      default:    prdata = '0;  // unmapped reads zero
    endcase
  end

endmodule : host_regs

`default_nettype wire

/* boot_memory/boot_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module boot_memory (
  input  logic                 fpga_clk_50,
  input  logic                 reset,
  input  board_pkg::mode_t     mode,
  input  board_pkg::sw_t       sw,          // raw slide switches
  // write port from host regs
  input  logic                 mem_we,
  input  board_pkg::mem_addr_t mem_waddr,
  input  board_pkg::mem_data_t mem_wdata,
  output board_pkg::sw_t       sw_sync,     // also read back by host
  output board_pkg::led_t      led
);
  import board_pkg::*;

  localparam int depth = 1 << `MEM_ADDR_WIDTH;

  mem_data_t mem [depth];   // 16 x 8 boot store
  sw_t       sw_meta;
  mem_addr_t rd_addr;       // stage 1
  mem_data_t rd_data;       // stage 2

  // ========================================
  // switch synchronizer
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (reset) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  // ========================================
  // array, write port and read pipe
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (mem_we) begin
      mem[mem_waddr] <= mem_wdata;  // host load
    end
    rd_addr <= mem_addr_t'(sw_sync); // address select, switches index entry
    rd_data <= mem[rd_addr];         // registered array read
  end

  // stage 3 led register
  // load mode freezes the display
  always_ff @(posedge fpga_clk_50) begin
    if (reset) begin
      led <= '0;
    end else if (mode == MODE_RUN) begin
      led <= led_t'(rd_data);
    end
  end

endmodule : boot_memory

`default_nettype wire

/* verilog/ghrd_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module ghrd_core #(
  parameter int debounce_cycles = `DEBOUNCE_CYCLES  // key stable time
) (
  input  logic                fpga_clk_50,
  input  logic                reset,
  // apb slave port from the hps bridge
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  host_pkg::apb_addr_t paddr,
  input  host_pkg::apb_data_t pwdata,
  output host_pkg::apb_data_t prdata,
  output logic                pready,
  output logic                pslverr,
  // board pins
  input  board_pkg::key_t     key,
  input  board_pkg::sw_t      sw,
  output board_pkg::led_t     led,
  // reset requests to the hps, low active
  output logic                hps_cold_reset_req_n,
  output logic                hps_warm_reset_req_n,
  output logic                hps_debug_reset_req_n
);
  import board_pkg::*;

  // ========================================
  // internal wires
  // ========================================
  key_t      keys_pressed;  // debounced, high = pressed
  sw_t       sw_sync;       // switches after sync
  mode_t     mode;
  logic      mem_we;
  mem_addr_t mem_waddr;
  mem_data_t mem_wdata;
  logic      cold_req;
  logic      warm_req;
  logic      debug_req;

  // ========================================
  // host register block
  // ========================================
  host_regs i_host_regs (
    .fpga_clk_50 (fpga_clk_50),  .reset     (reset),
    .psel        (psel),         .penable   (penable),
    .pwrite      (pwrite),       .paddr     (paddr),
    .pwdata      (pwdata),       .prdata    (prdata),
    .pready      (pready),       .pslverr   (pslverr),
    .keys_pressed(keys_pressed), .sw_sync   (sw_sync),
    .mode        (mode),         .mem_we    (mem_we),
    .mem_waddr   (mem_waddr),    .mem_wdata (mem_wdata),
    .cold_req    (cold_req),     .warm_req  (warm_req),
    .debug_req   (debug_req)
  );

  // 1 ms glitch filter at 50 MHz by default
  key_debounce #(.timeout(debounce_cycles)) i_key_debounce (
    .fpga_clk_50 (fpga_clk_50), .reset(reset),
    .key         (key),         .keys_pressed(keys_pressed)
  );

  boot_memory i_boot_memory (
    .fpga_clk_50 (fpga_clk_50), .reset    (reset),
    .mode        (mode),        .sw       (sw),
    .mem_we      (mem_we),      .mem_waddr(mem_waddr),
    .mem_wdata   (mem_wdata),   .sw_sync  (sw_sync),
    .led         (led)
  );

  // one stretcher per hps reset request
  reset_pulse #(.pulse_ext(`COLD_PULSE)) i_pulse_cold (
    .fpga_clk_50(fpga_clk_50), .reset(reset), .req(cold_req), .pulse_n(hps_cold_reset_req_n)
  );
  reset_pulse #(.pulse_ext(`WARM_PULSE)) i_pulse_warm (
    .fpga_clk_50(fpga_clk_50), .reset(reset), .req(warm_req), .pulse_n(hps_warm_reset_req_n)
  );
  reset_pulse #(.pulse_ext(`DEBUG_PULSE)) i_pulse_debug (
    .fpga_clk_50(fpga_clk_50), .reset(reset), .req(debug_req), .pulse_n(hps_debug_reset_req_n)
  );

endmodule : ghrd_core

`default_nettype wire

/* tb/ghrd_checks.svh */
`ifndef GHRD_CHECKS_SVH
`define GHRD_CHECKS_SVH

// ========================================
// compare tasks, one per result type
// ========================================
task automatic check_led(input string name, input led_t exp, input led_t act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("FAILED %0t %s expected %02h got %02h", $time, name, exp, act);
  end
endtask

task automatic check_keys(input string name, input key_t exp, input key_t act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("FAILED %0t %s expected %b got %b", $time, name, exp, act);
  end
endtask

task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("FAILED %0t %s expected %08h got %08h", $time, name, exp, act);
  end
endtask

task automatic check_pulse(input string name, input int exp, input int act);
  check_count++;
  if (act != exp) begin
    err_count++;
    $display("FAILED %0t %s expected %0d low cycles got %0d", $time, name, exp, act);
  end
endtask

// ========================================
// apb master, setup then access
// ========================================
task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
  int waited;
  waited = 0;
  @(posedge fpga_clk_50);
  psel    <= 1'b1;   // setup phase
  penable <= 1'b0;
  pwrite  <= wr;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge fpga_clk_50);
  penable <= 1'b1;   // access phase
  @(negedge fpga_clk_50);
  while (!pready && waited < 20) begin
    @(negedge fpga_clk_50);
    waited++;
  end
  if (!pready) begin
    err_count++;
    $display("timeout at %0t, pready never came for offset %h", $time, addr);
  end
  rdata = prdata;    // valid mid access cycle
  err   = pslverr;
  @(posedge fpga_clk_50);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
  apb_data_t unused;
  apb_access(addr, 1'b1, data, unused, err);
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
  apb_access(addr, 1'b0, '0, data, err);
endtask

// ========================================
// reset request outputs
// ========================================
function automatic logic req_n_of(input int which);
  case (which)
    0:       return hps_cold_reset_req_n;
    1:       return hps_warm_reset_req_n;
    default: return hps_debug_reset_req_n;
  endcase
endfunction

// wait up to wait_limit cycles for a low pulse, then count its length
task automatic measure_low(input int which, input int wait_limit, output bit seen,
                           output int len);
  int n;
  n    = 0;
  len  = 0;
  seen = 1'b0;
  @(negedge fpga_clk_50);
  while (req_n_of(which) && n < wait_limit) begin
    @(negedge fpga_clk_50);
    n++;
  end
  if (!req_n_of(which)) begin
    seen = 1'b1;
    while (!req_n_of(which) && len < 200) begin  // one count per low negedge
      len++;
      @(negedge fpga_clk_50);
    end
    if (len >= 200) begin
      err_count++;
      $display("timeout at %0t, reset request output %0d stuck low", $time, which);
    end
  end
endtask

`endif

/* tb/tb_ghrd_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module tb_ghrd_core;
  import board_pkg::*;
  import host_pkg::*;

  logic      fpga_clk_50;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  key_t      key;
  sw_t       sw;
  led_t      led;
  logic      hps_cold_reset_req_n;
  logic      hps_warm_reset_req_n;
  logic      hps_debug_reset_req_n;

  int        err_count = 0;
  int        check_count = 0;
  int        test_count = 0;
  int        test_fail = 0;
  int        errs_before;
  string     test_name;
  integer    seed = 26;

  // boot table: address, data, switch value, expected led
  mem_addr_t tbl_addr [16];
  mem_data_t tbl_data [16];
  sw_t       tbl_sw   [16];
  led_t      tbl_led  [16];
  // reset request table: ctrl bit, low cycles, output
  int        pulse_bit  [3] = '{1, 2, 3};
  int        pulse_len  [3] = '{6, 2, 32};
  string     pulse_name [3] = '{"hps_cold_reset_req_n", "hps_warm_reset_req_n",
                                 "hps_debug_reset_req_n"};
  int        glitch_len [3] = '{1, 6, 12};  // all under the 16 cycle filter

  `include "ghrd_checks.svh"

  ghrd_core #(.debounce_cycles(16)) i_ghrd_core (
    .fpga_clk_50(fpga_clk_50), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .key(key), .sw(sw), .led(led),
    .hps_cold_reset_req_n(hps_cold_reset_req_n),
    .hps_warm_reset_req_n(hps_warm_reset_req_n),
    .hps_debug_reset_req_n(hps_debug_reset_req_n)
  );

  initial begin
    fpga_clk_50 = 1'b0;
    forever #50 fpga_clk_50 = ~fpga_clk_50;  // 100 ns period
  end

  task automatic build_tables();
    for (int i = 0; i < 16; i++) begin
      tbl_addr[i] = mem_addr_t'(i);
      tbl_data[i] = mem_data_t'($random(seed));
      tbl_sw[i]   = sw_t'(i * 5 + 3);      // walks all 16 entries
    end
    for (int i = 0; i < 16; i++) tbl_led[i] = led_t'(tbl_data[tbl_sw[i]]);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    errs_before = err_count;
    test_count++;
  endtask

  task automatic finish_test();
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", test_count, test_name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_count, test_name, err_count - errs_before);
    end
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    apb_data_t rd;
    logic      err;
    bit        seen;
    int        len;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    key     = '1;      // buttons idle high
    sw      = '0;
    build_tables();
    repeat (16) @(posedge fpga_clk_50);
    reset <= 1'b0;
    @(negedge fpga_clk_50);

    start_test("reset state");
    check_led("led", '0, led);
    check_word("reset request outputs", 32'h7,
               {hps_cold_reset_req_n, hps_warm_reset_req_n, hps_debug_reset_req_n});
    apb_read(`REG_CTRL_OFF, rd, err);
    check_word("REG_CTRL", '0, rd);
    finish_test();

    start_test("load and run");
    for (int i = 0; i < 16; i++) begin
      apb_write(`REG_INSTR_OFF, {tbl_addr[i], tbl_data[i]}, err);
      apb_read(`REG_INSTR_OFF, rd, err);
      check_word("REG_INSTR", {tbl_addr[i], tbl_data[i]}, rd);
    end
    apb_write(`REG_CTRL_OFF, 32'h1, err);  // run mode
    for (int i = 0; i < 16; i++) begin
      @(posedge fpga_clk_50);
      sw <= tbl_sw[i];
      repeat (5) @(posedge fpga_clk_50);
      @(negedge fpga_clk_50);              // 5 cycles after the edge
      check_led("led", tbl_led[i], led);
    end
    for (int j = 0; j < 21; j++) begin     // new switch value every cycle
      @(posedge fpga_clk_50);
      if (j < 16) sw <= tbl_sw[j];
      @(negedge fpga_clk_50);
      if (j >= 5) check_led("led", tbl_led[j - 5], led);
    end
    finish_test();

    start_test("run mode write");
    @(posedge fpga_clk_50);
    sw <= 4'd5;
    repeat (6) @(posedge fpga_clk_50);
    apb_write(`REG_INSTR_OFF, {4'd5, ~tbl_data[5]}, err);  // must not reach memory
    repeat (6) @(posedge fpga_clk_50);
    @(negedge fpga_clk_50);
    check_led("led", tbl_data[5], led);
    finish_test();

    start_test("reset pulses");
    for (int p = 0; p < 3; p++) begin
      apb_write(`REG_CTRL_OFF, 32'h1 | (32'h1 << pulse_bit[p]), err);
      measure_low(p, 10, seen, len);
      if (!seen) begin
        err_count++;
        $display("timeout at %0t, no pulse on %s", $time, pulse_name[p]);
      end else begin
        check_pulse(pulse_name[p], pulse_len[p], len);
      end
      apb_write(`REG_CTRL_OFF, 32'h1, err);
      measure_low(p, 40, seen, len);
      if (seen) begin
        err_count++;
        $display("clearing the request gave a pulse on %s at %0t", pulse_name[p], $time);
      end
    end
    apb_write(`REG_CTRL_OFF, 32'h9, err);  // debug again, then retrigger mid pulse
    fork
      measure_low(2, 10, seen, len);
      begin
        repeat (4) @(posedge fpga_clk_50);
        apb_write(`REG_CTRL_OFF, 32'h1, err);
        apb_write(`REG_CTRL_OFF, 32'h9, err);
      end
    join
    check_pulse("hps_debug_reset_req_n retriggered", 32, len);
    apb_write(`REG_CTRL_OFF, 32'h1, err);
    finish_test();

    start_test("debounce");
    for (int g = 0; g < 3; g++) begin
      @(posedge fpga_clk_50);
      key <= (g % 2) ? 2'b01 : 2'b10;
      repeat (glitch_len[g]) @(posedge fpga_clk_50);
      key <= 2'b11;
      apb_read(`REG_STATUS_OFF, rd, err);  // a leaked glitch is still visible here
      check_keys("keys after glitch", 2'b00, key_t'(rd[1:0]));
      repeat (24) @(posedge fpga_clk_50);
    end
    @(posedge fpga_clk_50);
    key <= 2'b10;                          // hold key 0
    repeat (40) @(posedge fpga_clk_50);
    apb_read(`REG_STATUS_OFF, rd, err);
    check_keys("keys held", 2'b01, key_t'(rd[1:0]));
    check_word("REG_STATUS", {24'h0, 4'd5, 2'b00, 2'b01}, rd);
    key <= 2'b11;
    repeat (40) @(posedge fpga_clk_50);
    apb_read(`REG_STATUS_OFF, rd, err);
    check_keys("keys released", 2'b00, key_t'(rd[1:0]));
    finish_test();

    start_test("unmapped offset");
    apb_write(4'hc, 32'hffff_ffff, err);
    check_word("pslverr on write", 32'h1, 32'(err));
    apb_read(4'hc, rd, err);
    check_word("pslverr on read", 32'h1, 32'(err));
    apb_read(`REG_CTRL_OFF, rd, err);
    check_word("REG_CTRL", 32'h1, rd);
    apb_read(`REG_INSTR_OFF, rd, err);
    check_word("REG_INSTR", {20'h0, 4'd5, ~tbl_data[5]}, rd);
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_count, test_fail, check_count, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_ghrd_core

`default_nettype wire

/* tb.f */
+incdir+common
+incdir+tb
common/board_pkg.sv
common/host_pkg.sv
verilog/key_debounce.sv
reset_pulse/reset_pulse.sv
host_regs/host_regs.sv
boot_memory/boot_memory.sv
verilog/ghrd_core.sv
tb/tb_ghrd_core.sv
